// File: fft_consts.svh
`ifndef FFT_CONSTS_SVH
`define FFT_CONSTS_SVH

// number of points in one transform
`define FFT_N 16

// stage count, also the sample address width
`define FFT_LOG2N 4

// twiddle fraction bits, unity is 16384
`define TW_FRAC 14

// butterfly lanes, 1, 2 or 4
`define NUM_LANES 2

`endif

// File: logic/fft_pkg.sv
`include "fft_consts.svh"

package fft_pkg;

    // real or imaginary part of a sample
    typedef logic signed [15:0] sample_t;

    // twiddle part, Q1.14
    typedef logic signed [15:0] twiddle_t;

    typedef logic [`FFT_LOG2N-1:0] addr_t;
    typedef logic [`FFT_LOG2N-2:0] tw_idx_t;
    typedef logic [$clog2(`FFT_LOG2N)-1:0] stage_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_DRAIN,
        SEQ_DONE
    } seq_state_e;

endpackage

// File: logic/bfly_if.sv
`timescale 1ns/10ps

// one butterfly request per valid strobe
interface pair_if;
    logic             valid;
    fft_pkg::addr_t   addr_a;
    fft_pkg::addr_t   addr_b;
    fft_pkg::tw_idx_t tw_idx;

    modport sequencer (output valid, addr_a, addr_b, tw_idx);
    modport dispatch  (input valid, addr_a, addr_b, tw_idx);
endinterface

// operands into one lane
interface bfly_op_if;
    logic              valid;
    fft_pkg::sample_t  a_re, a_im, b_re, b_im;
    fft_pkg::twiddle_t w_re, w_im;
    fft_pkg::addr_t    addr_a, addr_b;

    modport source (output valid, a_re, a_im, b_re, b_im, w_re, w_im, addr_a, addr_b);
    modport sink   (input valid, a_re, a_im, b_re, b_im, w_re, w_im, addr_a, addr_b);
endinterface

// results out of one lane
interface bfly_res_if;
    logic             valid;
    fft_pkg::addr_t   addr_a, addr_b;
    fft_pkg::sample_t y0_re, y0_im, y1_re, y1_im;

    modport source (output valid, addr_a, addr_b, y0_re, y0_im, y1_re, y1_im);
    modport sink   (input valid, addr_a, addr_b, y0_re, y0_im, y1_re, y1_im);
endinterface

// File: logic/sample_store.sv
`timescale 1ns/10ps
`include "fft_consts.svh"

module sample_store (
    input  logic             clk,
    input  logic             rst_n,
    // load / unload port
    input  logic             io_we_i,
    input  fft_pkg::addr_t   io_addr_i,
    input  fft_pkg::sample_t io_wre_i,
    input  fft_pkg::sample_t io_wim_i,
    output fft_pkg::sample_t io_rre_o,
    output fft_pkg::sample_t io_rim_o,
    // butterfly operand reads
    input  fft_pkg::addr_t   rd_addr_a_i,
    input  fft_pkg::addr_t   rd_addr_b_i,
    output fft_pkg::sample_t rd_a_re_o,
    output fft_pkg::sample_t rd_a_im_o,
    output fft_pkg::sample_t rd_b_re_o,
    output fft_pkg::sample_t rd_b_im_o,
    // butterfly result writes
    input  logic             wr_en_a_i,
    input  fft_pkg::addr_t   wr_addr_a_i,
    input  fft_pkg::sample_t wr_a_re_i,
    input  fft_pkg::sample_t wr_a_im_i,
    input  logic             wr_en_b_i,
    input  fft_pkg::addr_t   wr_addr_b_i,
    input  fft_pkg::sample_t wr_b_re_i,
    input  fft_pkg::sample_t wr_b_im_i
);

    fft_pkg::sample_t mem_re [`FFT_N];
    fft_pkg::sample_t mem_im [`FFT_N];

    // asynchronous reads
    assign io_rre_o  = mem_re[io_addr_i];
    assign io_rim_o  = mem_im[io_addr_i];
    assign rd_a_re_o = mem_re[rd_addr_a_i];
    assign rd_a_im_o = mem_im[rd_addr_a_i];
    assign rd_b_re_o = mem_re[rd_addr_b_i];
    assign rd_b_im_o = mem_im[rd_addr_b_i];

    always_ff @(posedge clk) begin
        if (io_we_i) begin
            mem_re[io_addr_i] <= io_wre_i;
            mem_im[io_addr_i] <= io_wim_i;
        end
        if (wr_en_a_i) begin
            mem_re[wr_addr_a_i] <= wr_a_re_i;
            mem_im[wr_addr_a_i] <= wr_a_im_i;
        end
        if (wr_en_b_i) begin
            mem_re[wr_addr_b_i] <= wr_b_re_i;
            mem_im[wr_addr_b_i] <= wr_b_im_i;
        end
    end

    // loading never overlaps the in-place writes of a transform
    a_no_load_during_fft: assert property (@(posedge clk) disable iff (!rst_n)
        io_we_i |-> !(wr_en_a_i || wr_en_b_i));

    a_pair_addr_differ: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_en_a_i && wr_en_b_i) |-> (wr_addr_a_i != wr_addr_b_i));

endmodule

// File: logic/sample_io.sv
`timescale 1ns/10ps
`include "fft_consts.svh"

module sample_io (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_req_i,
    output logic             in_ack_o,
    input  fft_pkg::sample_t in_re_i,
    input  fft_pkg::sample_t in_im_i,
    output logic             out_req_o,
    input  logic             out_ack_i,
    output fft_pkg::sample_t out_re_o,
    output fft_pkg::sample_t out_im_o,
    output fft_pkg::addr_t   out_idx_o,
    output logic             busy_o,
    output logic             start_o,
    input  logic             done_i,
    output logic             io_we_o,
    output fft_pkg::addr_t   io_addr_o,
    output fft_pkg::sample_t io_wre_o,
    output fft_pkg::sample_t io_wim_o,
    input  fft_pkg::sample_t io_rre_i,
    input  fft_pkg::sample_t io_rim_i
);

    fft_pkg::addr_t in_cnt;
    fft_pkg::addr_t out_cnt;
    fft_pkg::addr_t rev_addr;
    logic           ack_wait;
    logic           out_last;

    always_comb begin
        for (int k = 0; k < `FFT_LOG2N; k++) begin
            rev_addr[k] = in_cnt[`FFT_LOG2N-1-k];
        end
    end

    // a sample is taken on the edge that raises ack
    assign io_we_o   = in_req_i && !in_ack_o && !busy_o;
    assign io_addr_o = busy_o ? out_cnt : rev_addr;
    assign io_wre_o  = in_re_i;
    assign io_wim_o  = in_im_i;

    assign out_re_o  = io_rre_i;
    assign out_im_o  = io_rim_i;
    assign out_idx_o = out_cnt;
    assign out_last  = out_req_o && out_ack_i && (out_cnt == `FFT_N-1);

    // ------------------------------------------------------------------------
    // input side, four-phase receiver
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_ack_o <= 1'b0;
            in_cnt   <= '0;
            start_o  <= 1'b0;
            busy_o   <= 1'b0;
        end else begin
            start_o <= 1'b0;
            if (io_we_o) begin
                in_ack_o <= 1'b1;
                in_cnt   <= in_cnt + 1'b1;
                if (in_cnt == `FFT_N-1) begin
                    busy_o  <= 1'b1;
                    start_o <= 1'b1;
                end
            end else if (in_ack_o && !in_req_i) begin
                in_ack_o <= 1'b0;
            end
            if (out_last) begin
                busy_o <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // output side, four-phase sender in natural order
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_req_o <= 1'b0;
            ack_wait  <= 1'b0;
            out_cnt   <= '0;
        end else if (done_i) begin
            out_req_o <= 1'b1;
        end else if (out_req_o && out_ack_i) begin
            out_req_o <= 1'b0;
            out_cnt   <= out_cnt + 1'b1;
            ack_wait  <= !out_last;
        end else if (ack_wait && !out_ack_i) begin
            out_req_o <= 1'b1;
            ack_wait  <= 1'b0;
        end
    end

    a_req_holds: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(out_req_o) |-> $past(out_ack_i));

endmodule

// File: logic/butterfly_sequencer.sv
`timescale 1ns/10ps
`include "fft_consts.svh"

module butterfly_sequencer (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start_i,
    input  logic      drained_i,
    pair_if.sequencer pair,
    output logic      done_o
);

    fft_pkg::seq_state_e      state;
    fft_pkg::stage_t          stage;
    logic [`FFT_LOG2N-2:0]    pair_idx;
    logic [`FFT_LOG2N-1:0]    j_ext, span, j_low, base;

    // stage addressing, span is 2**stage
    always_comb begin
        j_ext = {1'b0, pair_idx};
        span  = {{(`FFT_LOG2N-1){1'b0}}, 1'b1} << stage;
        j_low = j_ext & (span - 1'b1);
        base  = ((j_ext >> stage) << stage) << 1;
    end

    assign done_o = (state == fft_pkg::SEQ_DONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= fft_pkg::SEQ_IDLE;
            stage      <= '0;
            pair_idx   <= '0;
            pair.valid <= 1'b0;
        end else begin
            pair.valid <= 1'b0;
            case (state)
                fft_pkg::SEQ_IDLE: begin
                    stage    <= '0;
                    pair_idx <= '0;
                    if (start_i) state <= fft_pkg::SEQ_ISSUE;
                end
                fft_pkg::SEQ_ISSUE: begin
                    pair.valid <= 1'b1;
                    pair_idx   <= pair_idx + 1'b1;
                    if (&pair_idx) state <= fft_pkg::SEQ_DRAIN;
                end
                fft_pkg::SEQ_DRAIN: begin
                    // next stage reads what this one wrote
                    if (drained_i) begin
                        if (stage == `FFT_LOG2N-1) begin
                            state <= fft_pkg::SEQ_DONE;
                        end else begin
                            stage <= stage + 1'b1;
                            state <= fft_pkg::SEQ_ISSUE;
                        end
                    end
                end
                default: state <= fft_pkg::SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        pair.addr_a <= base + j_low;
        pair.addr_b <= base + j_low + span;
        pair.tw_idx <= fft_pkg::tw_idx_t'(j_low[`FFT_LOG2N-2:0] << (`FFT_LOG2N-1 - stage));
    end

    a_pair_distinct: assert property (@(posedge clk) disable iff (!rst_n)
        pair.valid |-> (pair.addr_a != pair.addr_b));

endmodule

// File: logic/bfly_dispatch.sv
`timescale 1ns/10ps
`include "fft_consts.svh"

module bfly_dispatch (
    input  logic             clk,
    input  logic             rst_n,
    pair_if.dispatch         pair,
    output fft_pkg::addr_t   rd_addr_a_o,
    output fft_pkg::addr_t   rd_addr_b_o,
    input  fft_pkg::sample_t rd_a_re_i,
    input  fft_pkg::sample_t rd_a_im_i,
    input  fft_pkg::sample_t rd_b_re_i,
    input  fft_pkg::sample_t rd_b_im_i,
    bfly_op_if.source        lanes [`NUM_LANES]
);

    logic [$clog2(`NUM_LANES+1)-1:0] lane_sel;
    fft_pkg::twiddle_t               w_re, w_im;

    assign rd_addr_a_o = pair.addr_a;
    assign rd_addr_b_o = pair.addr_b;

    // W16^k in Q1.14, imaginary part is -sin
    always_comb begin
        case (pair.tw_idx)
            3'd0:    begin w_re =  16'sd16384; w_im =  16'sd0;     end
            3'd1:    begin w_re =  16'sd15137; w_im = -16'sd6270;  end
            3'd2:    begin w_re =  16'sd11585; w_im = -16'sd11585; end
            3'd3:    begin w_re =  16'sd6270;  w_im = -16'sd15137; end
            3'd4:    begin w_re =  16'sd0;     w_im = -16'sd16384; end
            3'd5:    begin w_re = -16'sd6270;  w_im = -16'sd15137; end
            3'd6:    begin w_re = -16'sd11585; w_im = -16'sd11585; end
            default: begin w_re = -16'sd15137; w_im = -16'sd6270;  end
        endcase
    end

    // round robin over the lanes, one step per pair
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_sel <= '0;
        end else if (pair.valid) begin
            lane_sel <= (lane_sel == `NUM_LANES-1) ? '0 : lane_sel + 1'b1;
        end
    end

    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                lanes[i].valid <= 1'b0;
            end else begin
                lanes[i].valid <= pair.valid && (lane_sel == i);
            end
        end

        always_ff @(posedge clk) begin
            if (pair.valid && (lane_sel == i)) begin
                lanes[i].a_re   <= rd_a_re_i;
                lanes[i].a_im   <= rd_a_im_i;
                lanes[i].b_re   <= rd_b_re_i;
                lanes[i].b_im   <= rd_b_im_i;
                lanes[i].w_re   <= w_re;
                lanes[i].w_im   <= w_im;
                lanes[i].addr_a <= pair.addr_a;
                lanes[i].addr_b <= pair.addr_b;
            end
        end
    end

endmodule

// File: logic/bfly_lane.sv
`timescale 1ns/10ps
`include "fft_consts.svh"

module bfly_lane (
    input  logic       clk,
    input  logic       rst_n,
    bfly_op_if.sink    op,
    bfly_res_if.source res
);

    logic signed [31:0] p_re, p_im;
    logic signed [31:0] t_re_full, t_im_full;
    logic signed [17:0] s1_t_re, s1_t_im;
    logic signed [18:0] sum_re, sum_im, dif_re, dif_im;
    fft_pkg::sample_t   s1_a_re, s1_a_im;
    fft_pkg::addr_t     s1_addr_a, s1_addr_b;
    logic               s1_valid;

    // t = b * w, full product then drop the twiddle fraction
    assign p_re      = op.b_re * op.w_re - op.b_im * op.w_im;
    assign p_im      = op.b_re * op.w_im + op.b_im * op.w_re;
    assign t_re_full = p_re >>> `TW_FRAC;
    assign t_im_full = p_im >>> `TW_FRAC;

    assign sum_re = s1_a_re + s1_t_re;
    assign sum_im = s1_a_im + s1_t_im;
    assign dif_re = s1_a_re - s1_t_re;
    assign dif_im = s1_a_im - s1_t_im;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            res.valid <= 1'b0;
        end else begin
            s1_valid  <= op.valid;
            res.valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_a_re    <= op.a_re;
        s1_a_im    <= op.a_im;
        s1_t_re    <= t_re_full[17:0];
        s1_t_im    <= t_im_full[17:0];
        s1_addr_a  <= op.addr_a;
        s1_addr_b  <= op.addr_b;
        // halve every stage so the result stays in range
        res.y0_re  <= sum_re[16:1];
        res.y0_im  <= sum_im[16:1];
        res.y1_re  <= dif_re[16:1];
        res.y1_im  <= dif_im[16:1];
        res.addr_a <= s1_addr_a;
        res.addr_b <= s1_addr_b;
    end

endmodule

// File: logic/bfly_collect.sv
`timescale 1ns/10ps
`include "fft_consts.svh"

module bfly_collect (
    input  logic             clk,
    input  logic             rst_n,
    bfly_res_if.sink         results [`NUM_LANES],
    input  logic             issue_i,
    output logic             wr_en_a_o,
    output fft_pkg::addr_t   wr_addr_a_o,
    output fft_pkg::sample_t wr_a_re_o,
    output fft_pkg::sample_t wr_a_im_o,
    output logic             wr_en_b_o,
    output fft_pkg::addr_t   wr_addr_b_o,
    output fft_pkg::sample_t wr_b_re_o,
    output fft_pkg::sample_t wr_b_im_o,
    output logic             drained_o
);

    logic [`NUM_LANES-1:0] lane_vld;
    fft_pkg::addr_t        lane_addr_a [`NUM_LANES];
    fft_pkg::addr_t        lane_addr_b [`NUM_LANES];
    fft_pkg::sample_t      lane_y0_re  [`NUM_LANES];
    fft_pkg::sample_t      lane_y0_im  [`NUM_LANES];
    fft_pkg::sample_t      lane_y1_re  [`NUM_LANES];
    fft_pkg::sample_t      lane_y1_im  [`NUM_LANES];
    logic                  wr_en;
    logic [3:0]            in_flight;

    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_res
        assign lane_vld[i]    = results[i].valid;
        assign lane_addr_a[i] = results[i].addr_a;
        assign lane_addr_b[i] = results[i].addr_b;
        assign lane_y0_re[i]  = results[i].y0_re;
        assign lane_y0_im[i]  = results[i].y0_im;
        assign lane_y1_re[i]  = results[i].y1_re;
        assign lane_y1_im[i]  = results[i].y1_im;
    end

    assign wr_en_a_o = wr_en;
    assign wr_en_b_o = wr_en;
    assign drained_o = (in_flight == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_en     <= 1'b0;
            in_flight <= '0;
        end else begin
            wr_en     <= |lane_vld;
            in_flight <= in_flight + {3'b000, issue_i} - {3'b000, wr_en};
        end
    end

    // at most one lane finishes per cycle
    always_ff @(posedge clk) begin
        for (int i = 0; i < `NUM_LANES; i++) begin
            if (lane_vld[i]) begin
                wr_addr_a_o <= lane_addr_a[i];
                wr_addr_b_o <= lane_addr_b[i];
                wr_a_re_o   <= lane_y0_re[i];
                wr_a_im_o   <= lane_y0_im[i];
                wr_b_re_o   <= lane_y1_re[i];
                wr_b_im_o   <= lane_y1_im[i];
            end
        end
    end

    a_one_lane: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(lane_vld));

endmodule

// File: logic/fft_core.sv
`timescale 1ns/10ps
`include "fft_consts.svh"

module fft_core (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_req_i,
    output logic             in_ack_o,
    input  fft_pkg::sample_t in_re_i,
    input  fft_pkg::sample_t in_im_i,
    output logic             out_req_o,
    input  logic             out_ack_i,
    output fft_pkg::sample_t out_re_o,
    output fft_pkg::sample_t out_im_o,
    output fft_pkg::addr_t   out_idx_o,
    output logic             busy_o
);

    logic             start, done, drained;
    logic             io_we;
    fft_pkg::addr_t   io_addr;
    fft_pkg::sample_t io_wre, io_wim, io_rre, io_rim;
    fft_pkg::addr_t   rd_addr_a, rd_addr_b;
    fft_pkg::sample_t rd_a_re, rd_a_im, rd_b_re, rd_b_im;
    logic             wr_en_a, wr_en_b;
    fft_pkg::addr_t   wr_addr_a, wr_addr_b;
    fft_pkg::sample_t wr_a_re, wr_a_im, wr_b_re, wr_b_im;

    pair_if     pair_bus ();
    bfly_op_if  op_bus  [`NUM_LANES] ();
    bfly_res_if res_bus [`NUM_LANES] ();

    // ------------------------------------------------------------------------
    sample_io sample_io_inst (
        .clk, .rst_n, .in_req_i, .in_ack_o, .in_re_i, .in_im_i,
        .out_req_o, .out_ack_i, .out_re_o, .out_im_o, .out_idx_o, .busy_o,
        .start_o(start), .done_i(done), .io_we_o(io_we), .io_addr_o(io_addr),
        .io_wre_o(io_wre), .io_wim_o(io_wim), .io_rre_i(io_rre), .io_rim_i(io_rim)
    );

    sample_store sample_store_inst (
        .clk, .rst_n, .io_we_i(io_we), .io_addr_i(io_addr), .io_wre_i(io_wre),
        .io_wim_i(io_wim), .io_rre_o(io_rre), .io_rim_o(io_rim),
        .rd_addr_a_i(rd_addr_a), .rd_addr_b_i(rd_addr_b),
        .rd_a_re_o(rd_a_re), .rd_a_im_o(rd_a_im), .rd_b_re_o(rd_b_re), .rd_b_im_o(rd_b_im),
        .wr_en_a_i(wr_en_a), .wr_addr_a_i(wr_addr_a), .wr_a_re_i(wr_a_re), .wr_a_im_i(wr_a_im),
        .wr_en_b_i(wr_en_b), .wr_addr_b_i(wr_addr_b), .wr_b_re_i(wr_b_re), .wr_b_im_i(wr_b_im)
    );

    butterfly_sequencer butterfly_sequencer_inst (
        .clk, .rst_n, .start_i(start), .drained_i(drained), .pair(pair_bus), .done_o(done)
    );

    bfly_dispatch bfly_dispatch_inst (
        .clk, .rst_n, .pair(pair_bus), .rd_addr_a_o(rd_addr_a), .rd_addr_b_o(rd_addr_b),
        .rd_a_re_i(rd_a_re), .rd_a_im_i(rd_a_im), .rd_b_re_i(rd_b_re), .rd_b_im_i(rd_b_im),
        .lanes(op_bus)
    );

    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
        bfly_lane bfly_lane_inst (.clk, .rst_n, .op(op_bus[i]), .res(res_bus[i]));
    end

    bfly_collect bfly_collect_inst (
        .clk, .rst_n, .results(res_bus), .issue_i(pair_bus.valid),
        .wr_en_a_o(wr_en_a), .wr_addr_a_o(wr_addr_a), .wr_a_re_o(wr_a_re), .wr_a_im_o(wr_a_im),
        .wr_en_b_o(wr_en_b), .wr_addr_b_o(wr_addr_b), .wr_b_re_o(wr_b_re), .wr_b_im_o(wr_b_im),
        .drained_o(drained)
    );

endmodule

// File: tests/fft_tb.sv
`timescale 1ns/10ps
`include "fft_consts.svh"

module fft_tb;

    localparam int WAIT_LIMIT = 1000;

    logic             clk;
    logic             rst_n;
    logic             in_req_i;
    logic             in_ack_o;
    fft_pkg::sample_t in_re_i;
    fft_pkg::sample_t in_im_i;
    logic             out_req_o;
    logic             out_ack_i;
    fft_pkg::sample_t out_re_o;
    fft_pkg::sample_t out_im_o;
    fft_pkg::addr_t   out_idx_o;
    logic             busy_o;

    int     errors = 0;
    int     checks = 0;
    integer seed = 32'h43a42c5f;

    // one input block and the values expected back for it
    int in_re  [`FFT_N];
    int in_im  [`FFT_N];
    int exp_re [`FFT_N];
    int exp_im [`FFT_N];

    int recv_count;
    int recv_at_first_ack;

    // cosine at bin 1 with amplitude 8000
    int tone_tbl [`FFT_N] = '{8000, 7391, 5657, 3061, 0, -3061, -5657, -7391,
                              -8000, -7391, -5657, -3061, 0, 3061, 5657, 7391};

    fft_core fft_core_inst (
        .clk, .rst_n, .in_req_i, .in_ack_o, .in_re_i, .in_im_i,
        .out_req_o, .out_ack_i, .out_re_o, .out_im_o, .out_idx_o, .busy_o
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // checking helpers

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        checks++;
        assert (expected === actual) else begin
            errors++;
            $display("Error: %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic timeout_abort(input string what);
        errors++;
        $display("timeout: %s at %0t", what, $time);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    // handshake rules on both ports are sampled on the falling edge
    logic prev_in_req, prev_in_ack, prev_out_req, prev_out_ack, prev_busy;
    fft_pkg::sample_t prev_out_re, prev_out_im;
    fft_pkg::addr_t   prev_out_idx;

    always @(negedge clk) begin
        if (rst_n) begin
            assert (!(prev_in_ack && !in_ack_o && prev_in_req)) else begin
                errors++;
                $display("input ack dropped while req was still high at %0t", $time);
            end
            assert (!(!prev_in_ack && in_ack_o && (!prev_in_req || prev_busy))) else begin
                errors++;
                $display("input ack raised without req or while busy at %0t", $time);
            end
            assert (!(prev_out_req && !out_req_o && !prev_out_ack)) else begin
                errors++;
                $display("output req dropped before ack was seen at %0t", $time);
            end
            assert (!(prev_out_req && out_req_o && (out_re_o !== prev_out_re ||
                      out_im_o !== prev_out_im || out_idx_o !== prev_out_idx))) else begin
                errors++;
                $display("output data changed while req was high at %0t", $time);
            end
        end
        prev_in_req  = in_req_i;
        prev_in_ack  = in_ack_o;
        prev_out_req = out_req_o;
        prev_out_ack = out_ack_i;
        prev_busy    = busy_o;
        prev_out_re  = out_re_o;
        prev_out_im  = out_im_o;
        prev_out_idx = out_idx_o;
    end

    // ------------------------------------------------------------------------
    // integer fixed-point reference model

    function automatic int round_int(input real x);
        return (x >= 0.0) ? $rtoi(x + 0.5) : -$rtoi(0.5 - x);
    endfunction

    function automatic int twiddle_re(input int k);
        return round_int(16384.0 * $cos(2.0 * 3.14159265358979 * k / `FFT_N));
    endfunction

    function automatic int twiddle_im(input int k);
        return -round_int(16384.0 * $sin(2.0 * 3.14159265358979 * k / `FFT_N));
    endfunction

    function automatic int bit_reverse(input int n);
        int r;
        r = 0;
        for (int i = 0; i < `FFT_LOG2N; i++) begin
            r = (r << 1) | ((n >> i) & 1);
        end
        return r;
    endfunction

    task automatic compute_expected;
        int m_re [`FFT_N];
        int m_im [`FFT_N];
        int span, a, b, tw, t_re, t_im, w_re, w_im, y0_re, y0_im;
        for (int n = 0; n < `FFT_N; n++) begin
            m_re[bit_reverse(n)] = in_re[n];
            m_im[bit_reverse(n)] = in_im[n];
        end
        for (int s = 0; s < `FFT_LOG2N; s++) begin
            span = 1 << s;
            for (int j = 0; j < `FFT_N / 2; j++) begin
                a    = (j / span) * 2 * span + j % span;
                b    = a + span;
                tw   = (j % span) << (`FFT_LOG2N - 1 - s);
                w_re = twiddle_re(tw);
                w_im = twiddle_im(tw);
                t_re = (m_re[b] * w_re - m_im[b] * w_im) >>> `TW_FRAC;
                t_im = (m_re[b] * w_im + m_im[b] * w_re) >>> `TW_FRAC;
                y0_re = (m_re[a] + t_re) >>> 1;
                y0_im = (m_im[a] + t_im) >>> 1;
                m_re[b] = (m_re[a] - t_re) >>> 1;
                m_im[b] = (m_im[a] - t_im) >>> 1;
                m_re[a] = y0_re;
                m_im[a] = y0_im;
            end
        end
        for (int k = 0; k < `FFT_N; k++) begin
            exp_re[k] = m_re[k];
            exp_im[k] = m_im[k];
        end
    endtask

    // ------------------------------------------------------------------------
    // four-phase transfers

    task automatic send_block;
        int wait_cnt;
        for (int n = 0; n < `FFT_N; n++) begin
            in_re_i  = 16'(in_re[n]);
            in_im_i  = 16'(in_im[n]);
            in_req_i = 1'b1;
            wait_cnt = 0;
            while (!in_ack_o) begin
                next_cycle();
                wait_cnt++;
                if (wait_cnt > WAIT_LIMIT) timeout_abort("input ack never rose");
            end
            if (n == 0) recv_at_first_ack = recv_count;
            // req stays up one more cycle with ack high
            next_cycle();
            in_req_i = 1'b0;
            wait_cnt = 0;
            while (in_ack_o) begin
                next_cycle();
                wait_cnt++;
                if (wait_cnt > WAIT_LIMIT) timeout_abort("input ack never fell");
            end
        end
    endtask

    task automatic recv_block(input int max_delay);
        int wait_cnt;
        int delay;
        for (int k = 0; k < `FFT_N; k++) begin
            wait_cnt = 0;
            while (!out_req_o) begin
                next_cycle();
                wait_cnt++;
                if (wait_cnt > WAIT_LIMIT) timeout_abort("output req never rose");
            end
            check_value("out_idx_o", 16'(k), 16'(out_idx_o));
            check_value("out_re_o", 16'(exp_re[k]), out_re_o);
            check_value("out_im_o", 16'(exp_im[k]), out_im_o);
            delay = $unsigned($random(seed)) % (max_delay + 1);
            repeat (delay) next_cycle();
            out_ack_i = 1'b1;
            wait_cnt  = 0;
            while (out_req_o) begin
                next_cycle();
                wait_cnt++;
                if (wait_cnt > WAIT_LIMIT) timeout_abort("output req never fell");
            end
            out_ack_i = 1'b0;
            recv_count++;
        end
    endtask

    task automatic fill_random;
        for (int n = 0; n < `FFT_N; n++) begin
            in_re[n] = $random(seed) % 4001;
            in_im[n] = $random(seed) % 4001;
        end
    endtask

    // ------------------------------------------------------------------------
    // directed tests

    task automatic test_reset;
        check_value("in_ack_o", 16'd0, 16'(in_ack_o));
        check_value("out_req_o", 16'd0, 16'(out_req_o));
        check_value("busy_o", 16'd0, 16'(busy_o));
    endtask

    task automatic test_impulse;
        for (int n = 0; n < `FFT_N; n++) begin
            in_re[n]  = (n == 0) ? 1600 : 0;
            in_im[n]  = 0;
            exp_re[n] = 100;
            exp_im[n] = 0;
        end
        send_block();
        recv_block(0);
    endtask

    task automatic test_constant;
        for (int n = 0; n < `FFT_N; n++) begin
            in_re[n]  = 1600;
            in_im[n]  = 0;
            exp_re[n] = (n == 0) ? 1600 : 0;
            exp_im[n] = 0;
        end
        send_block();
        recv_block(0);
    endtask

    task automatic test_tone;
        for (int n = 0; n < `FFT_N; n++) begin
            in_re[n] = tone_tbl[n];
            in_im[n] = 0;
        end
        compute_expected();
        send_block();
        recv_block(0);
    endtask

    task automatic test_random_blocks;
        repeat (3) begin
            fill_random();
            compute_expected();
            send_block();
            recv_block(5);
        end
    endtask

    task automatic test_input_while_busy;
        fill_random();
        compute_expected();
        send_block();
        check_value("busy_o", 16'd1, 16'(busy_o));
        // second block waits at the input while the first drains out
        fill_random();
        recv_count = 0;
        fork
            send_block();
            recv_block(2);
        join
        assert (recv_at_first_ack == `FFT_N) else begin
            errors++;
            $display("second block was acknowledged before the first unload completed");
        end
        compute_expected();
        recv_block(2);
    endtask

    initial begin
        rst_n     = 1'b0;
        in_req_i  = 1'b0;
        in_re_i   = '0;
        in_im_i   = '0;
        out_ack_i = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();

        test_reset();
        test_impulse();
        test_constant();
        test_tone();
        test_random_blocks();
        test_input_while_busy();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+.
logic/fft_pkg.sv
logic/bfly_if.sv
logic/sample_store.sv
logic/sample_io.sv
logic/butterfly_sequencer.sv
logic/bfly_dispatch.sv
logic/bfly_lane.sv
logic/bfly_collect.sv
logic/fft_core.sv
tests/fft_tb.sv
